// File: all.f
verilog/wl_pkg.sv
verilog/load_sequencer.sv
verilog/weight_tile_buffer.sv
verilog/column_streamer.sv
verilog/weight_loader.sv
dv/weight_rom_model.sv
dv/weight_loader_tb.sv

// File: dv/weight_loader_tb.sv
module weight_loader_tb;
    import wl_pkg::*;

    logic                     clk;
    logic                     reset;
    logic                     start;
    logic                     stall;
    logic [LAYER_BITS-1:0]    layer_idx;
    logic [OUT_CH_BITS-1:0]   out_ch_idx;
    logic                     rom_read_enable;
    logic [ROM_ADDR_BITS-1:0] rom_addr;
    logic [31:0]              rom_data0, rom_data1, rom_data2, rom_data3;
    weight_vec_t              b0, b1, b2, b3;
    weight_vec_t              b_mon [SA_N];  // Columns indexable in loops
    logic                     idle;
    logic                     load_complete;

    int  seed = 59;
    bit  random_stall = 1'b0;
    int  active_cyc = 0;      // Unstalled cycles since reset
    int  mismatch_count = 0;
    int  fail_count = 0;
    logic [ROM_ADDR_BITS-1:0] addr_q [$];  // Issued ROM addresses
    logic [63:0]              mon_q  [$];  // {column, active cycle, vector}

    weight_loader i_dut (.*);

    weight_rom_model i_rom (
        .clk, .rom_read_enable, .rom_addr,
        .rom_data0, .rom_data1, .rom_data2, .rom_data3
    );

    assign b_mon[0] = b0;
    assign b_mon[1] = b1;
    assign b_mon[2] = b2;
    assign b_mon[3] = b3;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Stall pattern, roughly one cycle in four when enabled
    always @(posedge clk) begin
        #2;
        stall = random_stall && (($random(seed) & 3) == 0);
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rom_read_enable && stall) begin
            fail_count++;
            $display("%0t: rom_read_enable is high while stall is high", $time);
        end
        if (!reset && !stall) begin
            active_cyc++;
            if (rom_read_enable)
                addr_q.push_back(rom_addr);
            for (int c = 0; c < SA_N; c++) begin
                if (b_mon[c] != '0)  // Every ROM byte is nonzero
                    mon_q.push_back({2'(c), 30'(active_cyc), b_mon[c]});
            end
        end
    end

    // Kernel column c lives in rom_data(3-c), channel 0 in the top byte
    function automatic weight_vec_t expected_vec(input int addr, input int col);
        weight_vec_t v;
        for (int k = 0; k < VECTOR_WIDTH; k++)
            v[k] = 8'(((addr * 16 + (3 - col) * 4 + (3 - k)) % 251) + 1);
        return v;
    endfunction

    task automatic report_and_finish();
        $display("mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    // Holds start until the sequencer leaves idle, since a stall can swallow it
    task automatic start_load(input int layer, input int out_ch);
        int waited;
        waited = 0;
        addr_q.delete();
        mon_q.delete();
        @(posedge clk);
        #2;
        layer_idx  = LAYER_BITS'(layer);
        out_ch_idx = OUT_CH_BITS'(out_ch);
        start      = 1'b1;
        while (idle && waited < 50) begin
            @(posedge clk);
            #2;
            waited++;
        end
        start = 1'b0;
        if (idle) begin
            fail_count++;
            $display("start for layer %0d was not taken within 50 cycles", layer);
            report_and_finish();
        end
    endtask

    task automatic wait_load_complete(input int limit);
        int waited;
        waited = 0;
        while (!load_complete && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!load_complete) begin
            fail_count++;
            $display("load_complete did not rise within %0d cycles", limit);
            report_and_finish();
        end
    endtask

    task automatic check_load(input int layer, input int out_ch, input int groups);
        int addr;
        int n;
        int pos;
        weight_vec_t exp_vec;
        if (addr_q.size() != groups * KERNEL_SIZE) begin
            fail_count++;
            $display("layer %0d issued %0d ROM reads instead of %0d",
                     layer, addr_q.size(), groups * KERNEL_SIZE);
        end
        for (int g = 0; g < groups; g++) begin
            for (int row = 0; row < KERNEL_SIZE; row++) begin
                addr = int'(layer_base(layer)) + (out_ch * groups + g) * 4 + row;
                n    = g * KERNEL_SIZE + row;
                if (n < addr_q.size() && addr_q[n] != ROM_ADDR_BITS'(addr)) begin
                    mismatch_count++;
                    $display("mismatch at %0t: read %0d addr %0d, expected %0d",
                             $time, n, addr_q[n], addr);
                end
            end
        end
        for (int c = 0; c < SA_N; c++) begin
            n = 0;
            for (int i = 0; i < mon_q.size(); i++) begin
                if (mon_q[i][63:62] == 2'(c)) begin
                    pos = n % TILE_POSITIONS;  // Row-major tile position
                    addr = int'(layer_base(layer))
                         + (out_ch * groups + n / TILE_POSITIONS) * 4 + pos / 4;
                    exp_vec = expected_vec(addr, pos % 4);
                    if (n < groups * TILE_POSITIONS && mon_q[i][31:0] != exp_vec) begin
                        mismatch_count++;
                        $display("mismatch at %0t: col %0d vector %0d is %h, expected %h",
                                 $time, c, n, mon_q[i][31:0], exp_vec);
                    end
                    n++;
                end
            end
            if (n != groups * TILE_POSITIONS) begin
                fail_count++;
                $display("column %0d sent %0d weight vectors instead of %0d",
                         c, n, groups * TILE_POSITIONS);
            end
        end
        if (!load_complete || !idle) begin
            mismatch_count++;
            $display("mismatch at %0t: load_complete=%b idle=%b after load, expected 1 1",
                     $time, load_complete, idle);
        end
    endtask

    // Weight i of a group sits at skew + (i/4)*7 + i%4 after column 0's first
    task automatic check_timing();
        int t_ref [$];
        int seen [SA_N];
        int c;
        int g;
        int i;
        int exp_t;
        for (int k = 0; k < SA_N; k++)
            seen[k] = 0;
        for (int k = 0; k < mon_q.size(); k++) begin
            if (mon_q[k][63:62] == 2'd0 && seen[0] % TILE_POSITIONS == 0)
                t_ref.push_back(int'(mon_q[k][61:32]));
            if (mon_q[k][63:62] == 2'd0)
                seen[0]++;
        end
        seen[0] = 0;
        for (int k = 0; k < mon_q.size(); k++) begin
            c = int'(mon_q[k][63:62]);
            g = seen[c] / TILE_POSITIONS;
            i = seen[c] % TILE_POSITIONS;
            seen[c]++;
            if (g < t_ref.size()) begin
                exp_t = t_ref[g] + c + (i / WEIGHT_PHASE_CYCLES)
                      * (WEIGHT_PHASE_CYCLES + ZERO_PHASE_CYCLES) + i % WEIGHT_PHASE_CYCLES;
                if (int'(mon_q[k][61:32]) != exp_t) begin
                    mismatch_count++;
                    $display("mismatch at %0t: col %0d group %0d weight %0d at cycle %0d, exp %0d",
                             $time, c, g, i, int'(mon_q[k][61:32]), exp_t);
                end
            end
        end
    endtask

    task automatic load_and_check(input int layer, input int out_ch);
        int groups;
        groups = (CONV_IN_C[layer] + VECTOR_WIDTH - 1) / VECTOR_WIDTH;
        start_load(layer, out_ch);
        wait_load_complete(groups * 120 + 50);
        check_load(layer, out_ch, groups);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        if (!idle || load_complete || rom_read_enable ||
            b0 != '0 || b1 != '0 || b2 != '0 || b3 != '0) begin
            mismatch_count++;
            $display("mismatch at %0t: after reset idle=%b load_complete=%b rd=%b b=%h %h %h %h",
                     $time, idle, load_complete, rom_read_enable, b0, b1, b2, b3);
        end
    endtask

    task automatic test_two_group_load();
        load_and_check(1, 3);  // 8 input channels, two groups
    endtask

    task automatic test_skew_and_gaps();
        load_and_check(1, 5);
        check_timing();
    endtask

    task automatic test_random_stall();
        random_stall = 1'b1;
        load_and_check(2, 7);
        random_stall = 1'b0;
    endtask

    // Both loads start from MAIN_DONE
    task automatic test_restart();
        load_and_check(0, 5);  // Single group at the very start of the ROM
        load_and_check(5, 9);  // Last layer, base covers all earlier layers
    endtask

    initial begin
        reset      = 1'b1;
        start      = 1'b0;
        stall      = 1'b0;
        layer_idx  = '0;
        out_ch_idx = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_state();
        test_two_group_load();
        test_skew_and_gaps();
        test_random_stall();
        test_restart();
        report_and_finish();
    end

endmodule

// File: dv/weight_rom_model.sv
module weight_rom_model (
    input  logic                             clk,
    input  logic                             rom_read_enable,
    input  logic [wl_pkg::ROM_ADDR_BITS-1:0] rom_addr,
    output logic [31:0]                      rom_data0,  // Kernel column 3
    output logic [31:0]                      rom_data1,  // Kernel column 2
    output logic [31:0]                      rom_data2,  // Kernel column 1
    output logic [31:0]                      rom_data3   // Kernel column 0
);
    // Byte p of word w at address a is ((a*16 + w*4 + p) mod 251) + 1, never zero
    function automatic logic [31:0] word_at(input int addr, input int w);
        logic [31:0] word;
        for (int p = 0; p < 4; p++)
            word[8*p +: 8] = 8'(((addr * 16 + w * 4 + p) % 251) + 1);
        return word;
    endfunction

    initial begin
        rom_data0 = '0;  // Defined value before the first read
        rom_data1 = '0;
        rom_data2 = '0;
        rom_data3 = '0;
    end

    // One-cycle read latency, independent of stall
    always @(posedge clk) begin
        if (rom_read_enable) begin
            rom_data0 <= word_at(int'(rom_addr), 0);
            rom_data1 <= word_at(int'(rom_addr), 1);
            rom_data2 <= word_at(int'(rom_addr), 2);
            rom_data3 <= word_at(int'(rom_addr), 3);
        end
    end

endmodule

// File: verilog/column_streamer.sv
module column_streamer #(
    parameter int COL_IDX = 0  // Column number, also its skew in cycles
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    stall,
    input  logic                                    stream_go,
    input  wl_pkg::weight_vec_t                     rd_vec,    // Buffer data at rd_pos
    output logic [$clog2(wl_pkg::TILE_POSITIONS)-1:0] rd_pos,
    output wl_pkg::weight_vec_t                     b,
    output logic                                    col_done
);
    import wl_pkg::*;

    col_state_t                        state;
    logic [1:0]                        delay_cnt;
    logic [2:0]                        phase_cnt;  // Cycle within a weight or zero phase
    logic [$clog2(TILE_POSITIONS)-1:0] pos;        // Wraps to 0 after the 16th weight

    assign rd_pos   = pos;
    assign col_done = (state == COL_DONE);
    assign b        = (state == COL_WEIGHT) ? rd_vec : '0;  // Zero outside weight runs

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= COL_IDLE;
            delay_cnt <= '0;
            phase_cnt <= '0;
            pos       <= '0;
        end else if (!stall) begin
            case (state)
                COL_IDLE, COL_DONE: begin
                    if (stream_go) begin
                        delay_cnt <= '0;
                        phase_cnt <= '0;
                        pos       <= '0;
                        state     <= (COL_IDX == 0) ? COL_WEIGHT : COL_DELAY;
                    end
                end
                COL_DELAY: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == 2'(COL_IDX - 1))
                        state <= COL_WEIGHT;
                end
                COL_WEIGHT: begin
                    pos <= pos + 1'b1;
                    if (phase_cnt == 3'(WEIGHT_PHASE_CYCLES - 1)) begin
                        phase_cnt <= '0;
                        state     <= COL_ZERO;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                COL_ZERO: begin
                    if (phase_cnt == 3'(ZERO_PHASE_CYCLES - 1)) begin
                        phase_cnt <= '0;
                        // pos back at 0 means all 16 positions went out
                        state     <= (pos == '0) ? COL_DONE : COL_WEIGHT;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                default: state <= COL_IDLE;
            endcase
        end
    end

    // Runs are exactly 4 long, gaps exactly 3
    a_phase_bounds: assert property (
        @(posedge clk) disable iff (reset)
        !((state == COL_WEIGHT && phase_cnt >= 3'(WEIGHT_PHASE_CYCLES)) ||
          (state == COL_ZERO   && phase_cnt >= 3'(ZERO_PHASE_CYCLES)))
    );

endmodule

// File: verilog/load_sequencer.sv
module load_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,       // Taken in MAIN_IDLE or MAIN_DONE
    input  logic                             stall,
    input  logic [wl_pkg::LAYER_BITS-1:0]    layer_idx,
    input  logic [wl_pkg::OUT_CH_BITS-1:0]   out_ch_idx,
    input  logic [wl_pkg::SA_N-1:0]          col_done,    // One level per column streamer
    output logic                             rom_read_enable,
    output logic [wl_pkg::ROM_ADDR_BITS-1:0] rom_addr,
    output logic                             group_start, // First read of a group
    output logic                             stream_go,   // Kicks all columns
    output logic                             idle,
    output logic                             load_complete
);
    import wl_pkg::*;

    main_state_t                    state;
    logic [$clog2(KERNEL_SIZE)-1:0] row_cnt;     // Reads issued in this group
    logic [GROUP_BITS-1:0]          group_cnt;
    logic [GROUP_BITS-1:0]          num_groups;
    logic                           go_pending;  // First MAIN_STREAM cycle not yet taken
    logic                           all_done;
    logic [ROM_ADDR_BITS-1:0]       tile_idx;    // Tile number inside the layer

    assign num_groups = layer_groups(int'(layer_idx));
    assign all_done   = &col_done;

    // Every unstalled MAIN_LOAD cycle issues a read, so row_cnt tracks issued reads
    assign rom_read_enable = (state == MAIN_LOAD) && !stall;
    assign group_start     = rom_read_enable && (row_cnt == '0);
    assign stream_go       = (state == MAIN_STREAM) && go_pending;
    assign idle            = (state == MAIN_IDLE) || (state == MAIN_DONE);
    assign load_complete   = (state == MAIN_DONE);

    // base + (out_ch * groups + group) * 4 + row
    always_comb begin
        tile_idx = ROM_ADDR_BITS'(out_ch_idx) * ROM_ADDR_BITS'(num_groups)
                 + ROM_ADDR_BITS'(group_cnt);
        rom_addr = layer_base(int'(layer_idx))
                 + tile_idx * ROM_ADDR_BITS'(KERNEL_SIZE)
                 + ROM_ADDR_BITS'(row_cnt);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= MAIN_IDLE;
            row_cnt    <= '0;
            group_cnt  <= '0;
            go_pending <= 1'b0;
        end else if (!stall) begin  // Everything freezes on stall
            case (state)
                MAIN_IDLE, MAIN_DONE: begin
                    if (start) begin
                        state     <= MAIN_LOAD;
                        row_cnt   <= '0;
                        group_cnt <= '0;
                    end
                end
                MAIN_LOAD: begin
                    row_cnt <= row_cnt + 1'b1;  // Wraps to 0 after the last row
                    if (int'(row_cnt) == KERNEL_SIZE - 1) begin
                        state      <= MAIN_STREAM;
                        go_pending <= 1'b1;
                    end
                end
                MAIN_STREAM: begin
                    go_pending <= 1'b0;
                    // col_done is stale on the stream_go cycle, columns still in COL_DONE
                    if (!go_pending && all_done) begin
                        if (group_cnt == num_groups - 1'b1) begin
                            state <= MAIN_DONE;
                        end else begin
                            group_cnt <= group_cnt + 1'b1;
                            state     <= MAIN_LOAD;
                        end
                    end
                end
                default: state <= MAIN_IDLE;
            endcase
        end
    end

    // No ROM traffic outside an active load
    a_no_read_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == MAIN_IDLE || state == MAIN_DONE) |-> !rom_read_enable
    );

    // Group counter stays inside the selected layer while working
    a_group_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (state == MAIN_LOAD || state == MAIN_STREAM) |-> (group_cnt < num_groups)
    );

endmodule

// File: verilog/weight_loader.sv
module weight_loader (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             stall,
    input  logic [wl_pkg::LAYER_BITS-1:0]    layer_idx,   // Held from start to load_complete
    input  logic [wl_pkg::OUT_CH_BITS-1:0]   out_ch_idx,
    output logic                             rom_read_enable,
    output logic [wl_pkg::ROM_ADDR_BITS-1:0] rom_addr,
    input  logic [31:0]                      rom_data0,
    input  logic [31:0]                      rom_data1,
    input  logic [31:0]                      rom_data2,
    input  logic [31:0]                      rom_data3,
    output wl_pkg::weight_vec_t              b0,          // Array column 0
    output wl_pkg::weight_vec_t              b1,
    output wl_pkg::weight_vec_t              b2,
    output wl_pkg::weight_vec_t              b3,
    output logic                             idle,
    output logic                             load_complete
);
    import wl_pkg::*;

    logic                              group_start;
    logic                              stream_go;
    logic [SA_N-1:0]                   col_done;
    logic [$clog2(TILE_POSITIONS)-1:0] rd_pos [SA_N];
    weight_vec_t                       rd_vec [SA_N];
    weight_vec_t                       b_col  [SA_N];

    load_sequencer i_sequencer (
        .clk, .reset, .start, .stall, .layer_idx, .out_ch_idx, .col_done,
        .rom_read_enable, .rom_addr, .group_start, .stream_go, .idle, .load_complete
    );

    weight_tile_buffer i_buffer (
        .clk, .reset, .rom_read_enable, .group_start,
        .rom_data0, .rom_data1, .rom_data2, .rom_data3,
        .rd_pos0(rd_pos[0]), .rd_pos1(rd_pos[1]), .rd_pos2(rd_pos[2]), .rd_pos3(rd_pos[3]),
        .rd_vec0(rd_vec[0]), .rd_vec1(rd_vec[1]), .rd_vec2(rd_vec[2]), .rd_vec3(rd_vec[3])
    );

    // Column c is skewed by c cycles
    for (genvar c = 0; c < SA_N; c++) begin : g_col
        column_streamer #(.COL_IDX(c)) i_col (
            .clk, .reset, .stall, .stream_go,
            .rd_vec   (rd_vec[c]),
            .rd_pos   (rd_pos[c]),
            .b        (b_col[c]),
            .col_done (col_done[c])
        );
    end

    assign b0 = b_col[0];
    assign b1 = b_col[1];
    assign b2 = b_col[2];
    assign b3 = b_col[3];

endmodule

// File: verilog/weight_tile_buffer.sv
module weight_tile_buffer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    rom_read_enable,
    input  logic                                    group_start,   // Rewinds the write row
    input  logic [31:0]                             rom_data0,     // Kernel column 3
    input  logic [31:0]                             rom_data1,     // Kernel column 2
    input  logic [31:0]                             rom_data2,     // Kernel column 1
    input  logic [31:0]                             rom_data3,     // Kernel column 0
    input  logic [$clog2(wl_pkg::TILE_POSITIONS)-1:0] rd_pos0,
    input  logic [$clog2(wl_pkg::TILE_POSITIONS)-1:0] rd_pos1,
    input  logic [$clog2(wl_pkg::TILE_POSITIONS)-1:0] rd_pos2,
    input  logic [$clog2(wl_pkg::TILE_POSITIONS)-1:0] rd_pos3,
    output wl_pkg::weight_vec_t                     rd_vec0,
    output wl_pkg::weight_vec_t                     rd_vec1,
    output wl_pkg::weight_vec_t                     rd_vec2,
    output wl_pkg::weight_vec_t                     rd_vec3
);
    import wl_pkg::*;

    logic                                data_valid;  // ROM word arrives this cycle
    logic [2:0]                          wr_row;      // Bit 2 only flags an overrun
    logic [$clog2(TILE_POSITIONS)-1:0]   wr_base;
    weight_vec_t                         tile_mem [TILE_POSITIONS];

    // Channel 0 sits in the top byte of a ROM word
    function automatic weight_vec_t word_to_vec(input logic [31:0] word);
        weight_vec_t v;
        for (int k = 0; k < VECTOR_WIDTH; k++)
            v[k] = word[8*(VECTOR_WIDTH-k)-1 -: 8];
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid <= 1'b0;
            wr_row     <= '0;
        end else begin
            data_valid <= rom_read_enable;  // Fixed one-cycle ROM latency, stall or not
            if (group_start)
                wr_row <= '0;
            else if (data_valid)
                wr_row <= wr_row + 1'b1;
        end
    end

    assign wr_base = {wr_row[1:0], 2'b00};  // row * 4

    // One ROM word fills a whole kernel row
    always_ff @(posedge clk) begin
        if (data_valid) begin
            tile_mem[wr_base]        <= word_to_vec(rom_data3);
            tile_mem[wr_base + 4'd1] <= word_to_vec(rom_data2);
            tile_mem[wr_base + 4'd2] <= word_to_vec(rom_data1);
            tile_mem[wr_base + 4'd3] <= word_to_vec(rom_data0);
        end
    end

    assign rd_vec0 = tile_mem[rd_pos0];
    assign rd_vec1 = tile_mem[rd_pos1];
    assign rd_vec2 = tile_mem[rd_pos2];
    assign rd_vec3 = tile_mem[rd_pos3];

    // At most four rows land per group
    a_four_writes_per_group: assert property (
        @(posedge clk) disable iff (reset)
        data_valid |-> (wr_row < 3'd4)
    );

endmodule

// File: verilog/wl_pkg.sv
package wl_pkg;

    // Array and tile geometry
    localparam int VECTOR_WIDTH        = 4;   // Input channels per vector / per ROM word
    localparam int KERNEL_SIZE         = 4;   // Kernel rows and columns
    localparam int SA_N                = 4;   // Systolic array columns
    localparam int TILE_POSITIONS      = 16;  // Row-major, pos = row*4 + col
    localparam int WEIGHT_PHASE_CYCLES = 4;   // Weight run length per column
    localparam int ZERO_PHASE_CYCLES   = 3;   // Zero gap after each run

    // Network layer table
    localparam int NUM_LAYERS = 6;
    localparam int CONV_IN_C  [NUM_LAYERS] = '{1, 8, 16, 32, 256, 64};
    localparam int CONV_OUT_C [NUM_LAYERS] = '{8, 16, 32, 64, 64, 10};

    localparam int ROM_ADDR_BITS = 15;  // Whole network is 19744 words
    localparam int LAYER_BITS    = 3;
    localparam int OUT_CH_BITS   = 6;
    localparam int GROUP_BITS    = 7;   // Up to 64 groups (layer 4)

    typedef logic signed [7:0] int8_t;
    typedef int8_t [VECTOR_WIDTH-1:0] weight_vec_t;  // Element k is channel k of the group

    typedef enum logic [1:0] {
        MAIN_IDLE,
        MAIN_LOAD,    // Issuing the four row reads of one group
        MAIN_STREAM,  // Columns draining the buffered tile
        MAIN_DONE
    } main_state_t;

    typedef enum logic [2:0] {
        COL_IDLE,
        COL_DELAY,   // Skew before the first weight
        COL_WEIGHT,
        COL_ZERO,
        COL_DONE
    } col_state_t;

    // Groups of four input channels, rounded up
    function automatic logic [GROUP_BITS-1:0] layer_groups(input int layer);
        return GROUP_BITS'((CONV_IN_C[layer] + VECTOR_WIDTH - 1) / VECTOR_WIDTH);
    endfunction

    // First ROM word of a layer, four words per channel group and output channel
    function automatic logic [ROM_ADDR_BITS-1:0] layer_base(input int layer);
        logic [ROM_ADDR_BITS-1:0] base;
        base = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (i < layer)
                base = base + ROM_ADDR_BITS'(CONV_OUT_C[i] * int'(layer_groups(i)) * KERNEL_SIZE);
        end
        return base;
    endfunction

endpackage
